// File: source/sched_consts.svh
// Scheduler widths and depths, included by the packages and by every RTL file that sizes a port
`ifndef SCHED_CONSTS_SVH
`define SCHED_CONSTS_SVH

`define XLEN       32
`define FETCH_LEN  2                         // Words from fetch per cycle
`define QUEUE_LEN  2                         // Hold queue depth
`define CODE_LEN   (`FETCH_LEN + `QUEUE_LEN) // Window, queue entries first
`define EXEC_LEN   2
`define MEMB_LEN   4
`define RFBUF_LEN  4
`define RGLEN      31                        // x1..x31, x0 never busy

// Counts and lane indices, one extra code for full or none
`define MEMB_OFF   $clog2(`MEMB_LEN + 1)
`define RFBUF_OFF  $clog2(`RFBUF_LEN + 1)
`define EXEC_OFF   $clog2(`EXEC_LEN + 1)
`define QUEUE_OFF  $clog2(`QUEUE_LEN + 1)
`define FETCH_OFF  $clog2(`FETCH_LEN + 1)

`endif

// File: source/rv_decode_pkg.sv
// Types of a decoded RV32I instruction, imported by the decoder and the scheduling logic
`include "sched_consts.svh"

package rv_decode_pkg;

	typedef logic [`XLEN-1:0] word_t; // Instruction or pc
	typedef logic [4:0] reg_idx_t;

	// Class flags, one hot for a valid instruction
	typedef struct packed {
		logic mul;    // Reserved, always zero
		logic fencei;
		logic fence;
		logic sys;
		logic csr;
		logic jump;
		logic branch;
		logic mem;
		logic alu;
	} instr_class_t;

	// Decode kept with a held entry so it is not decoded twice
	typedef struct packed {
		logic mem;
		logic alu;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs0;
	} queue_para_t;

endpackage

// File: source/sched_pkg.sv
// Scheduler bookkeeping types: busy masks, buffer counts and lane indices
`include "sched_consts.svh"

package sched_pkg;

	typedef logic [`RGLEN-1:0] reg_mask_t;     // Bit n-1 stands for xn
	typedef logic [`MEMB_OFF-1:0] memb_cnt_t;
	typedef logic [`RFBUF_OFF-1:0] rfbuf_cnt_t;
	typedef logic [`EXEC_OFF-1:0] exec_idx_t;  // EXEC_LEN means none
	typedef logic [`QUEUE_OFF-1:0] queue_idx_t; // QUEUE_LEN means none
	typedef logic [`FETCH_OFF-1:0] fetch_cnt_t;

	// Busy mask bit of one register, empty for x0
	function automatic reg_mask_t reg_bit(input logic [4:0] r);
		if (r == 5'd0)
			return '0;
		return reg_mask_t'(1) << (r - 5'd1);
	endfunction

endpackage

// File: source/rv_class_decoder.sv
// Sorts one fetched RV32I word into its scheduling class and register numbers
module rv_class_decoder import rv_decode_pkg::*; (
	input word_t instr,
	input logic vld,
	output instr_class_t cls,
	output reg_idx_t rd,
	output reg_idx_t rs1,
	output reg_idx_t rs0
);

	always_comb begin
		cls = '0;
		rd = '0;
		rs1 = '0;
		rs0 = '0;
		if (vld) begin
			case (instr[6:0])
			7'b0110111,
			7'b0010111: begin // LUI, AUIPC
				cls.alu = 1'b1;
				rd = instr[11:7];
			end
			7'b1101111: begin // JAL
				cls.jump = 1'b1;
				rd = instr[11:7];
			end
			7'b1100111: begin // JALR
				cls.jump = 1'b1;
				rd = instr[11:7];
				rs0 = instr[19:15];
			end
			7'b1100011: begin
				cls.branch = 1'b1;
				rs1 = instr[24:20];
				rs0 = instr[19:15];
			end
			7'b0000011: begin // Loads
				cls.mem = 1'b1;
				rd = instr[11:7];
				rs0 = instr[19:15];
			end
			7'b0100011: begin // Stores
				cls.mem = 1'b1;
				rs1 = instr[24:20];
				rs0 = instr[19:15];
			end
			7'b0010011: begin
				cls.alu = 1'b1;
				rd = instr[11:7];
				rs0 = instr[19:15];
			end
			7'b0110011: begin
				// funct7 bit 0 is the M extension, not supported here
				if (instr[25]) begin
					cls.sys = 1'b1;
				end else begin
					cls.alu = 1'b1;
					rd = instr[11:7];
					rs1 = instr[24:20];
					rs0 = instr[19:15];
				end
			end
			7'b0001111: begin
				cls.fencei = instr[12];
				cls.fence = ~instr[12];
			end
			7'b1110011: begin
				if (instr[14:12] == 3'b000) begin // ECALL, EBREAK, xRET
					cls.sys = 1'b1;
				end else begin
					cls.csr = 1'b1;
					rd = instr[11:7];
					rs0 = instr[14] ? 5'd0 : instr[19:15]; // zimm forms
				end
			end
			default: cls.sys = 1'b1; // Illegal, let the trap path order it
			endcase
		end
	end

endmodule

// File: source/issue_slot.sv
// One link of the issue chain: tests hazards, chooses lane or queue entry, passes bookkeeping on
`include "sched_consts.svh"

module issue_slot import rv_decode_pkg::*, sched_pkg::*; #(
	parameter bit from_fetch = 1'b1
) (
	input instr_class_t cls,
	input reg_idx_t rd,
	input reg_idx_t rs1,
	input reg_idx_t rs0,
	input reg_mask_t busy_rs_in,
	input reg_mask_t busy_rd_in,
	input reg_mask_t wb_mask_in,
	input memb_cnt_t memb_in,
	input memb_cnt_t cnt_in,
	input rfbuf_cnt_t rfbuf_in,
	input exec_idx_t exec_in,
	input queue_idx_t queue_in,
	output reg_mask_t busy_rs_out,
	output reg_mask_t busy_rd_out,
	output reg_mask_t wb_mask_out,
	output memb_cnt_t memb_out,
	output memb_cnt_t cnt_out,
	output rfbuf_cnt_t rfbuf_out,
	output exec_idx_t exec_out,
	output queue_idx_t queue_out,
	output exec_idx_t go_exec,
	output queue_idx_t go_queue,
	output logic placed
);

	localparam exec_idx_t EXEC_NONE = exec_idx_t'(`EXEC_LEN);
	localparam queue_idx_t QUEUE_NONE = queue_idx_t'(`QUEUE_LEN);

	reg_mask_t rd_bit;
	reg_mask_t src_bits;
	logic rg_hit;
	logic mem_hit;
	logic alu_hit;
	logic lanes_full;
	logic queue_full;
	logic special;
	logic special_ok;

	//////////////////////////////////////////////////////////////////////
	// Hazards

	assign rd_bit = reg_bit(rd);
	assign src_bits = reg_bit(rs0) | reg_bit(rs1);

	// RAW on the sources, WAW and WAR on rd
	assign rg_hit = (|(busy_rs_in & src_bits)) | (|(busy_rd_in & rd_bit));

	assign lanes_full = (exec_in == EXEC_NONE);
	assign queue_full = (queue_in == QUEUE_NONE);

	// memb differs from cnt once an older access sits in the queue
	assign mem_hit = rg_hit | (memb_in == memb_cnt_t'(`MEMB_LEN)) | (memb_in != cnt_in);
	assign alu_hit = rg_hit | ((rfbuf_in == rfbuf_cnt_t'(`RFBUF_LEN)) & (rd != '0));

	assign special = from_fetch &
		(cls.jump | cls.branch | cls.csr | cls.fence | cls.fencei | cls.sys);

	always_comb begin
		if (lanes_full)
			special_ok = 1'b0;
		else if (cls.fencei | cls.sys)
			special_ok = (queue_in == '0) && (cnt_in == '0);
		else if (cls.fence)
			special_ok = (cnt_in == '0);
		else
			special_ok = ~alu_hit; // Jump, branch, csr
	end

	//////////////////////////////////////////////////////////////////////
	// Placement and bookkeeping

	always_comb begin
		busy_rs_out = busy_rs_in;
		busy_rd_out = busy_rd_in;
		wb_mask_out = wb_mask_in;
		memb_out = memb_in;
		cnt_out = cnt_in;
		rfbuf_out = rfbuf_in;
		exec_out = exec_in;
		queue_out = queue_in;
		go_exec = EXEC_NONE;
		go_queue = QUEUE_NONE;

		if (special) begin
			if (special_ok) begin
				go_exec = exec_idx_t'(`EXEC_LEN - 1);
				if (cls.jump | cls.branch | cls.csr)
					rfbuf_out = rfbuf_in + rfbuf_cnt_t'(rd != '0);
			end
			// Nothing later in the window moves past it
			exec_out = EXEC_NONE;
			queue_out = QUEUE_NONE;
		end else if (cls.mem | cls.alu) begin
			if ((cls.mem ? mem_hit : alu_hit) | lanes_full) begin
				if (queue_full) begin
					exec_out = EXEC_NONE; // Keep program order
				end else begin
					go_queue = queue_in;
					queue_out = queue_in + 1'b1;
				end
				busy_rs_out = busy_rs_in | rd_bit;
				busy_rd_out = busy_rd_in | rd_bit | src_bits;
				if (cls.mem && cnt_in != memb_cnt_t'(`MEMB_LEN))
					cnt_out = cnt_in + 1'b1;
			end else begin
				go_exec = exec_in;
				exec_out = exec_in + 1'b1;
				busy_rs_out = busy_rs_in | rd_bit;
				if (cls.mem) begin
					memb_out = memb_in + 1'b1;
					cnt_out = cnt_in + 1'b1;
					busy_rd_out = busy_rd_in | rd_bit;
					wb_mask_out = wb_mask_in | rd_bit; // Busy until mem_sel
				end else begin
					rfbuf_out = rfbuf_in + rfbuf_cnt_t'(rd != '0);
				end
			end
		end
	end

	assign placed = (go_exec != EXEC_NONE) | (go_queue != QUEUE_NONE);

endmodule

// File: source/lane_packer.sv
// Gathers window items into the lanes picked for them; instanced once per payload kind
`include "sched_consts.svh"

module lane_packer #(
	parameter type payload_t = logic,
	parameter int lanes = 2,
	localparam int pick_w = $clog2(lanes + 1)
) (
	input payload_t item [`CODE_LEN],
	input logic [pick_w-1:0] pick [`CODE_LEN],
	output payload_t lane [lanes]
);

	// Scan from the back so the oldest slot wins a lane
	always_comb begin
		for (int l = 0; l < lanes; l++) begin
			lane[l] = '0;
			for (int i = `CODE_LEN - 1; i >= 0; i--) begin
				if (pick[i] == pick_w'(l))
					lane[l] = item[i]; // "none" never matches a lane
			end
		end
	end

endmodule

// File: source/sched_state.sv
// State kept between cycles: held instructions, busy list and buffer counts, with releases applied
`include "sched_consts.svh"

module sched_state import rv_decode_pkg::*, sched_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t next_instr [`QUEUE_LEN],
	input word_t next_pc [`QUEUE_LEN],
	input logic [`QUEUE_LEN-1:0] next_vld,
	input queue_para_t next_para [`QUEUE_LEN],
	input reg_mask_t end_mask,
	input memb_cnt_t end_memb,
	input rfbuf_cnt_t end_rfbuf,
	input rfbuf_cnt_t rf_release,
	input logic mem_release,
	input reg_idx_t mem_sel,
	output word_t queue_instr [`QUEUE_LEN],
	output word_t queue_pc [`QUEUE_LEN],
	output logic [`QUEUE_LEN-1:0] queue_vld,
	output queue_para_t queue_para [`QUEUE_LEN],
	output reg_mask_t start_mask,
	output memb_cnt_t start_memb,
	output rfbuf_cnt_t start_rfbuf
);

	reg_mask_t mask_q;
	memb_cnt_t memb_q;
	rfbuf_cnt_t rfbuf_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			queue_vld <= '0;
			mask_q <= '0;
			memb_q <= '0;
			rfbuf_q <= '0;
		end else begin
			queue_vld <= next_vld;
			mask_q <= end_mask;
			memb_q <= end_memb;
			rfbuf_q <= end_rfbuf;
		end
	end

	always_ff @(posedge clk) begin
		queue_instr <= next_instr;
		queue_pc <= next_pc;
		queue_para <= next_para;
	end

	// Releases count in the same cycle they arrive
	assign start_mask = mask_q & ~reg_bit(mem_sel);
	assign start_memb = memb_q - memb_cnt_t'(mem_release);
	assign start_rfbuf = rfbuf_q - rf_release;

endmodule

// File: source/schedule.sv
// Issue scheduler top: window of held and fetched words, slot chain, lane packing, state
`include "sched_consts.svh"

module schedule import rv_decode_pkg::*, sched_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t fetch_instr [`FETCH_LEN],
	input word_t fetch_pc [`FETCH_LEN],
	input logic [`FETCH_LEN-1:0] fetch_vld,
	input rfbuf_cnt_t rf_release,
	input logic mem_release,
	input reg_idx_t mem_sel,
	output word_t exec_instr [`EXEC_LEN],
	output word_t exec_pc [`EXEC_LEN],
	output logic [`EXEC_LEN-1:0] exec_vld,
	output memb_cnt_t exec_cnt [`EXEC_LEN],
	output fetch_cnt_t core_offset
);

	word_t queue_instr [`QUEUE_LEN];
	word_t queue_pc [`QUEUE_LEN];
	logic [`QUEUE_LEN-1:0] queue_vld;
	queue_para_t queue_para [`QUEUE_LEN];
	word_t next_instr [`QUEUE_LEN];
	word_t next_pc [`QUEUE_LEN];
	logic [`QUEUE_LEN-1:0] next_vld;
	queue_para_t next_para [`QUEUE_LEN];
	reg_mask_t start_mask;
	memb_cnt_t start_memb;
	rfbuf_cnt_t start_rfbuf;

	// Window, held entries in the low slots
	word_t win_instr [`CODE_LEN];
	word_t win_pc [`CODE_LEN];
	instr_class_t win_cls [`CODE_LEN];
	queue_para_t win_para [`CODE_LEN];

	// Bookkeeping entering each slot, last element leaves the chain
	reg_mask_t busy_rs [`CODE_LEN+1];
	reg_mask_t busy_rd [`CODE_LEN+1];
	reg_mask_t wb_mask [`CODE_LEN+1];
	memb_cnt_t memb [`CODE_LEN+1];
	memb_cnt_t cnt [`CODE_LEN+1];
	rfbuf_cnt_t rfbuf [`CODE_LEN+1];
	exec_idx_t exec_at [`CODE_LEN+1];
	queue_idx_t queue_at [`CODE_LEN+1];

	exec_idx_t go_exec [`CODE_LEN];
	queue_idx_t go_queue [`CODE_LEN];
	logic [`CODE_LEN-1:0] placed;
	memb_cnt_t slot_cnt [`CODE_LEN];
	logic [`CODE_LEN-1:0] exec_hit [`EXEC_LEN];
	logic [`CODE_LEN-1:0] queue_hit [`QUEUE_LEN];
	fetch_cnt_t offset [`FETCH_LEN+1];

	//////////////////////////////////////////////////////////////////////
	// Window

	for (genvar q = 0; q < `QUEUE_LEN; q++) begin : g_queue
		assign win_instr[q] = queue_instr[q];
		assign win_pc[q] = queue_pc[q];
		assign win_para[q] = queue_para[q];
		// Held entries are only ever mem or alu
		assign win_cls[q] = {7'b0, queue_vld[q] & queue_para[q].mem,
			queue_vld[q] & queue_para[q].alu};
	end

	assign offset[0] = '0;

	for (genvar f = 0; f < `FETCH_LEN; f++) begin : g_fetch
		instr_class_t cls;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs0;

		rv_class_decoder u_decoder (
			.instr(fetch_instr[f]),
			.vld(fetch_vld[f]),
			.cls(cls),
			.rd(rd),
			.rs1(rs1),
			.rs0(rs0)
		);

		assign win_instr[`QUEUE_LEN+f] = fetch_instr[f];
		assign win_pc[`QUEUE_LEN+f] = fetch_pc[f];
		assign win_cls[`QUEUE_LEN+f] = cls;
		assign win_para[`QUEUE_LEN+f] = {cls.mem, cls.alu, rd, rs1, rs0};
		assign offset[f+1] = offset[f] + fetch_cnt_t'(placed[`QUEUE_LEN+f]);
	end

	assign core_offset = offset[`FETCH_LEN];

	//////////////////////////////////////////////////////////////////////
	// Slot chain

	assign busy_rs[0] = start_mask;
	assign busy_rd[0] = start_mask;
	assign wb_mask[0] = start_mask;
	assign memb[0] = start_memb;
	assign cnt[0] = start_memb;
	assign rfbuf[0] = start_rfbuf;
	assign exec_at[0] = '0;
	assign queue_at[0] = '0;

	for (genvar i = 0; i < `CODE_LEN; i++) begin : g_slot
		issue_slot #(
			.from_fetch(i >= `QUEUE_LEN)
		) u_slot (
			.cls(win_cls[i]),
			.rd(win_para[i].rd),
			.rs1(win_para[i].rs1),
			.rs0(win_para[i].rs0),
			.busy_rs_in(busy_rs[i]),
			.busy_rd_in(busy_rd[i]),
			.wb_mask_in(wb_mask[i]),
			.memb_in(memb[i]),
			.cnt_in(cnt[i]),
			.rfbuf_in(rfbuf[i]),
			.exec_in(exec_at[i]),
			.queue_in(queue_at[i]),
			.busy_rs_out(busy_rs[i+1]),
			.busy_rd_out(busy_rd[i+1]),
			.wb_mask_out(wb_mask[i+1]),
			.memb_out(memb[i+1]),
			.cnt_out(cnt[i+1]),
			.rfbuf_out(rfbuf[i+1]),
			.exec_out(exec_at[i+1]),
			.queue_out(queue_at[i+1]),
			.go_exec(go_exec[i]),
			.go_queue(go_queue[i]),
			.placed(placed[i])
		);

		assign slot_cnt[i] = cnt[i]; // Memory order tag
	end

	//////////////////////////////////////////////////////////////////////
	// Lanes and next queue

	for (genvar l = 0; l < `EXEC_LEN; l++) begin : g_exec_vld
		for (genvar i = 0; i < `CODE_LEN; i++) begin : g_hit
			assign exec_hit[l][i] = (go_exec[i] == exec_idx_t'(l));
		end
		assign exec_vld[l] = |exec_hit[l];
	end

	for (genvar l = 0; l < `QUEUE_LEN; l++) begin : g_queue_vld
		for (genvar i = 0; i < `CODE_LEN; i++) begin : g_hit
			assign queue_hit[l][i] = (go_queue[i] == queue_idx_t'(l));
		end
		assign next_vld[l] = |queue_hit[l];
	end

	lane_packer #(.payload_t(word_t), .lanes(`EXEC_LEN)) u_exec_instr (
		.item(win_instr), .pick(go_exec), .lane(exec_instr));
	lane_packer #(.payload_t(word_t), .lanes(`EXEC_LEN)) u_exec_pc (
		.item(win_pc), .pick(go_exec), .lane(exec_pc));
	lane_packer #(.payload_t(memb_cnt_t), .lanes(`EXEC_LEN)) u_exec_cnt (
		.item(slot_cnt), .pick(go_exec), .lane(exec_cnt));
	lane_packer #(.payload_t(word_t), .lanes(`QUEUE_LEN)) u_queue_instr (
		.item(win_instr), .pick(go_queue), .lane(next_instr));
	lane_packer #(.payload_t(word_t), .lanes(`QUEUE_LEN)) u_queue_pc (
		.item(win_pc), .pick(go_queue), .lane(next_pc));
	lane_packer #(.payload_t(queue_para_t), .lanes(`QUEUE_LEN)) u_queue_para (
		.item(win_para), .pick(go_queue), .lane(next_para));

	sched_state u_state (
		.clk(clk),
		.reset(reset),
		.next_instr(next_instr),
		.next_pc(next_pc),
		.next_vld(next_vld),
		.next_para(next_para),
		.end_mask(wb_mask[`CODE_LEN]),
		.end_memb(memb[`CODE_LEN]),
		.end_rfbuf(rfbuf[`CODE_LEN]),
		.rf_release(rf_release),
		.mem_release(mem_release),
		.mem_sel(mem_sel),
		.queue_instr(queue_instr),
		.queue_pc(queue_pc),
		.queue_vld(queue_vld),
		.queue_para(queue_para),
		.start_mask(start_mask),
		.start_memb(start_memb),
		.start_rfbuf(start_rfbuf)
	);

endmodule

// File: testbench/tb_clock.sv
// Clock and reset source for the scheduler testbench; instance it once and connect clk and reset
module tb_clock #(
	parameter int period = 100,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Release away from the rising edge
	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: testbench/schedule_assertions.sv
// Output rules of the issue scheduler as concurrent assertions; bound to every schedule instance
`include "sched_consts.svh"

module schedule_assertions import rv_decode_pkg::*, sched_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [`FETCH_LEN-1:0] fetch_vld,
	input logic [`EXEC_LEN-1:0] exec_vld,
	input word_t last_instr,
	input fetch_cnt_t core_offset
);

	logic packed_lanes;
	logic last_alone;
	logic special_last;
	int vld_words;

	// Only loads, stores and integer ops may share lanes
	function automatic logic mem_or_alu(input word_t w);
		case (w[6:0])
		7'b0110111, 7'b0010111, 7'b0000011, 7'b0100011, 7'b0010011: return 1'b1;
		7'b0110011: return ~w[25];
		default: return 1'b0;
		endcase
	endfunction

	assign packed_lanes = ((exec_vld + 1'b1) & exec_vld) == '0; // 0..01..1 form
	assign last_alone = exec_vld[`EXEC_LEN-1] && ($countones(exec_vld) == 1);
	assign special_last = ~mem_or_alu(last_instr);
	assign vld_words = $countones(fetch_vld);

	lanes_from_zero: assert property (@(posedge clk) disable iff (reset)
		packed_lanes || (last_alone && special_last))
		else $error("exec_vld %b leaves a gap below an issued lane", exec_vld);

	offset_in_range: assert property (@(posedge clk) disable iff (reset)
		32'(core_offset) <= vld_words)
		else $error("core_offset %0d is more than the valid fetch words", core_offset);

endmodule

// File: testbench/schedule_tb.sv
// Testbench for the issue scheduler: replays the cycle patterns from the hex file and checks lanes
`include "sched_consts.svh"

module schedule_tb import rv_decode_pkg::*, sched_pkg::*; ();

	localparam int N_PATS = 22;
	localparam int COLS = 14;     // Words per pattern line
	localparam int PERIOD = 100;
	localparam int WATCHDOG = (N_PATS + 10) * PERIOD;

	logic clk;
	logic reset;
	word_t fetch_instr [`FETCH_LEN];
	word_t fetch_pc [`FETCH_LEN];
	logic [`FETCH_LEN-1:0] fetch_vld;
	rfbuf_cnt_t rf_release;
	logic mem_release;
	reg_idx_t mem_sel;
	word_t exec_instr [`EXEC_LEN];
	word_t exec_pc [`EXEC_LEN];
	logic [`EXEC_LEN-1:0] exec_vld;
	memb_cnt_t exec_cnt [`EXEC_LEN];
	fetch_cnt_t core_offset;

	logic [31:0] pat [N_PATS*COLS];
	logic [31:0] instr_at_pc [logic [31:0]]; // Every word fetched, by pc
	int errors;
	int checks;

	tb_clock #(
		.period(PERIOD),
		.reset_cycles(3)
	) u_clock (
		.clk(clk),
		.reset(reset)
	);

	schedule u_schedule (
		.clk(clk),
		.reset(reset),
		.fetch_instr(fetch_instr),
		.fetch_pc(fetch_pc),
		.fetch_vld(fetch_vld),
		.rf_release(rf_release),
		.mem_release(mem_release),
		.mem_sel(mem_sel),
		.exec_instr(exec_instr),
		.exec_pc(exec_pc),
		.exec_vld(exec_vld),
		.exec_cnt(exec_cnt),
		.core_offset(core_offset)
	);

	bind schedule schedule_assertions u_assertions (
		.clk(clk),
		.reset(reset),
		.fetch_vld(fetch_vld),
		.exec_vld(exec_vld),
		.last_instr(exec_instr[`EXEC_LEN-1]),
		.core_offset(core_offset)
	);

	//////////////////////////////////////////////////////////////////////
	// Drive and compare

	task automatic check_word(input int k, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s got %h expected %h in pattern %0d", name, got, exp, k);
		end
	endtask

	task automatic apply_inputs(input int k);
		int base;
		base = k * COLS;
		fetch_instr[0] = pat[base];
		fetch_instr[1] = pat[base + 1];
		fetch_pc[0] = pat[base + 2];
		fetch_pc[1] = pat[base + 3];
		fetch_vld = pat[base + 4][1:0];
		rf_release = rfbuf_cnt_t'(pat[base + 5]);
		mem_release = pat[base + 6][0];
		mem_sel = pat[base + 7][4:0];
		for (int f = 0; f < `FETCH_LEN; f++) begin
			if (fetch_vld[f])
				instr_at_pc[fetch_pc[f]] = fetch_instr[f];
		end
	endtask

	task automatic check_outputs(input int k);
		int base;
		logic [31:0] exp_pc;
		base = k * COLS;
		check_word(k, "exec_vld", 32'(exec_vld), pat[base + 8]);
		check_word(k, "exec_pc[0]", exec_pc[0], pat[base + 9]);
		check_word(k, "exec_pc[1]", exec_pc[1], pat[base + 10]);
		check_word(k, "exec_cnt[0]", 32'(exec_cnt[0]), pat[base + 11]);
		check_word(k, "exec_cnt[1]", 32'(exec_cnt[1]), pat[base + 12]);
		check_word(k, "core_offset", 32'(core_offset), pat[base + 13]);
		// Issued word must be the one fetched at that pc
		for (int l = 0; l < `EXEC_LEN; l++) begin
			exp_pc = pat[base + 9 + l];
			if (pat[base + 8][l]) begin
				checks++;
				assert (instr_at_pc.exists(exp_pc)) else begin
					errors++;
					$display("Pattern %0d expects lane %0d to issue a pc that was never fetched",
						k, l);
				end
				if (instr_at_pc.exists(exp_pc))
					check_word(k, $sformatf("exec_instr[%0d]", l), exec_instr[l],
						instr_at_pc[exp_pc]);
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		foreach (fetch_instr[f]) begin
			fetch_instr[f] = '0;
			fetch_pc[f] = '0;
		end
		fetch_vld = '0;
		rf_release = '0;
		mem_release = 1'b0;
		mem_sel = '0;
		errors = 0;
		checks = 0;
		$readmemh("testbench/schedule_patterns.hex", pat);

		@(posedge clk);
		for (int k = 0; k < N_PATS; k++) begin
			@(negedge clk);
			apply_inputs(k);
			#(PERIOD / 2 - 10); // Just before the rising edge
			check_outputs(k);
		end
		@(negedge clk);

		$display("Patterns %0d, checks %0d, errors %0d", N_PATS, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("Watchdog expired before all patterns were applied");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: testbench/schedule_patterns.hex
// fetch_instr0 fetch_instr1 fetch_pc0 fetch_pc1 fetch_vld rf_release mem_release mem_sel
// then expected exec_vld exec_pc0 exec_pc1 exec_cnt0 exec_cnt1 core_offset, one line per cycle
00000000 00000000 00000000 00000000 0 0 0 00 0 00000000 00000000 0 0 0
00000000 00000000 00000000 00000000 0 0 0 00 0 00000000 00000000 0 0 0
00000000 00000000 00000000 00000000 0 0 0 00 0 00000000 00000000 0 0 0
00100093 00200113 00000100 00000104 3 0 0 00 3 00000100 00000104 0 0 2
00400213 00120193 00000108 0000010c 3 0 0 00 1 00000108 00000000 0 0 2
00000000 00000000 00000000 00000000 0 0 0 00 1 0000010c 00000000 0 0 0
00100093 00200113 00000110 00000114 3 0 0 00 0 00000000 00000000 0 0 2
00000000 00000000 00000000 00000000 0 1 0 00 1 00000110 00000000 0 0 0
00400213 00000000 00000118 00000000 1 4 0 00 3 00000114 00000118 0 0 1
00002283 00002303 00000200 00000204 3 0 0 00 3 00000200 00000204 0 1 2
00002383 00002403 00000208 0000020c 3 0 0 00 3 00000208 0000020c 2 3 2
00002483 00000000 00000210 00000000 1 0 0 00 0 00000000 00000000 0 0 1
00002503 00000000 00000214 00000000 1 0 1 05 1 00000210 00000000 3 0 1
0ff0000f 00000000 00000218 00000000 1 0 0 00 0 00000000 00000000 0 0 0
0ff0000f 00000000 00000218 00000000 1 0 1 06 1 00000214 00000000 3 0 0
0ff0000f 00000000 00000218 00000000 1 0 1 07 0 00000000 00000000 0 0 0
0ff0000f 00000000 00000218 00000000 1 0 1 08 0 00000000 00000000 0 0 0
0ff0000f 00000000 00000218 00000000 1 0 1 09 0 00000000 00000000 0 0 0
0ff0000f 00000000 00000218 00000000 1 0 1 0a 2 00000000 00000218 0 0 1
00002583 00158613 00000300 00000304 3 0 0 00 1 00000300 00000000 0 0 2
00000000 00000000 00000000 00000000 0 0 0 00 0 00000000 00000000 0 0 0
00000000 00000000 00000000 00000000 0 0 1 0b 1 00000304 00000000 0 0 0

// File: compile.f
+incdir+source
source/rv_decode_pkg.sv
source/sched_pkg.sv
source/rv_class_decoder.sv
source/issue_slot.sv
source/lane_packer.sv
source/sched_state.sv
source/schedule.sv
testbench/tb_clock.sv
testbench/schedule_assertions.sv
testbench/schedule_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert
TOP ?= schedule_tb
FILELIST ?= compile.f
OBJDIR ?= obj_dir
LOG ?= sim.log

SIM := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
